//--- all.f
sdlxPkg.sv
aluControl.sv
alu.sv
regFile.sv
decodeStage.sv
executeStage.sv
sdlxExec.sv
sdlxExecTb.sv

//--- alu.sv
`timescale 1ns/100ps

module alu #(
   parameter int dataWidth = 32                    // Datapath width, 8 to 32
) (
   input  logic [dataWidth-1:0] a,                 // Operand A
   input  logic [dataWidth-1:0] b,                 // Operand B or shift amount
   input  sdlxPkg::aluOp_t      op,                // Operation select
   output logic [dataWidth-1:0] y                  // Result
);

   import sdlxPkg::*;

   localparam int SHIFT_BITS = $clog2(dataWidth);  // Shift amount width

   logic [SHIFT_BITS-1:0] shamt;

   assign shamt = b[SHIFT_BITS-1:0];               // Upper bits of B ignored

   always_comb begin
      case (op)
         aluAnd: begin
            y = a & b;
         end
         aluOr: begin
            y = a | b;
         end
         aluShl: begin
            y = a << shamt;                        // Zero fill
         end
         aluShr: begin
            y = a >> shamt;                        // Logical, zero fill
         end
         aluAdd: begin
            y = a + b;                             // Wraps at dataWidth
         end
         aluSub: begin
            y = a - b;                             // Wraps at dataWidth
         end
         aluMul: begin
            y = a * b;                             // Low half of product
         end
         default: begin
            y = '0;
         end
      endcase
   end

endmodule

//--- aluControl.sv
`timescale 1ns/100ps

module aluControl (
   input  sdlxPkg::opcode_t opcode,                // Primary opcode
   input  sdlxPkg::func_t   func,                  // Function field, R-type only
   output sdlxPkg::aluOp_t  op,                    // Selected ALU operation
   output logic             legal                  // Low for unsupported encodings
);

   import sdlxPkg::*;

   always_comb begin
      op    = aluAnd;                              // Harmless default
      legal = 1'b1;
      case (opcode)
         OP_RTYPE: begin
            case (func)
               FN_AND: op = aluAnd;
               FN_OR:  op = aluOr;
               FN_SLL: op = aluShl;
               FN_SRL: op = aluShr;
               FN_ADD: op = aluAdd;
               FN_SUB: op = aluSub;
               FN_MUL: op = aluMul;
               default: begin
                  op    = aluAnd;                  // Unknown function
                  legal = 1'b0;
               end
            endcase
         end
         OP_ADDI: begin
            op = aluAdd;                           // rs1 plus sign-extended imm
         end
         default: begin
            op    = aluAnd;                        // Loads, stores, branches etc
            legal = 1'b0;
         end
      endcase
   end

endmodule

//--- decodeStage.sv
`timescale 1ns/100ps

module decodeStage #(
   parameter int dataWidth = 32                    // Datapath width
) (
   input  logic                               clk,
   input  logic                               rst,
   input  logic                               instrValid,  // Instruction strobe
   input  logic [sdlxPkg::INSTR_WIDTH-1:0]    instr,       // Instruction word
   output sdlxPkg::regIdx_t                   rdAddrA,     // To regFile port A
   output sdlxPkg::regIdx_t                   rdAddrB,     // To regFile port B
   input  logic [dataWidth-1:0]               rdDataA,
   input  logic [dataWidth-1:0]               rdDataB,
   input  logic                               wrEn,        // Writeback from execute
   input  sdlxPkg::regIdx_t                   wrAddr,
   input  logic [dataWidth-1:0]               wrData,
   output logic                               exValid,     // Legal instruction in execute
   output logic                               exIllegal,   // Illegal instruction in execute
   output sdlxPkg::aluOp_t                    exOp,
   output logic [dataWidth-1:0]               exA,
   output logic [dataWidth-1:0]               exB,
   output sdlxPkg::regIdx_t                   exDest
);

   import sdlxPkg::*;

   localparam int IMM_WIDTH = IMM_HI - IMM_LO + 1;

   opcode_t                opcode;
   func_t                  func;
   regIdx_t                rs1;
   regIdx_t                rs2;
   regIdx_t                rd;
   regIdx_t                dest;
   logic [IMM_WIDTH-1:0]   imm;
   logic [INSTR_WIDTH-1:0] immExt;
   logic                   isRType;
   aluOp_t                 op;
   logic                   legal;
   logic [dataWidth-1:0]   opA;
   logic [dataWidth-1:0]   regB;
   logic [dataWidth-1:0]   opB;

   // Field split
   assign opcode = instr[OPC_HI:OPC_LO];
   assign rs1    = instr[RS1_HI:RS1_LO];
   assign rs2    = instr[RS2_HI:RS2_LO];
   assign rd     = instr[RD_HI:RD_LO];
   assign imm    = instr[IMM_HI:IMM_LO];
   assign func   = instr[FN_HI:FN_LO];

   assign isRType = (opcode == OP_RTYPE);
   assign dest    = isRType ? rd : rs2;            // ADDI writes the rs2 slot

   aluControl aluCtrl (
      .opcode (opcode),
      .func   (func),
      .op     (op),
      .legal  (legal)
   );

   assign rdAddrA = rs1;
   assign rdAddrB = rs2;

   // Bypass from the instruction now in execute
   assign opA  = (wrEn && (wrAddr != '0) && (wrAddr == rs1)) ? wrData : rdDataA;
   assign regB = (wrEn && (wrAddr != '0) && (wrAddr == rs2)) ? wrData : rdDataB;

   assign immExt = {{(INSTR_WIDTH-IMM_WIDTH){imm[IMM_WIDTH-1]}}, imm}; // Sign extend
   assign opB    = isRType ? regB : immExt[dataWidth-1:0];              // Then truncate

   always_ff @(posedge clk) begin
      if (rst) begin
         exValid   <= 1'b0;
         exIllegal <= 1'b0;
         exOp      <= aluAnd;
      end else begin
         exValid   <= instrValid & legal;
         exIllegal <= instrValid & ~legal;         // Flag only, no effect
         exOp      <= op;
      end
   end

   always_ff @(posedge clk) begin
      exA    <= opA;
      exB    <= opB;
      exDest <= dest;
   end

endmodule

//--- executeStage.sv
`timescale 1ns/100ps

module executeStage #(
   parameter int dataWidth = 32                    // Datapath width
) (
   input  logic                 clk,
   input  logic                 rst,
   input  logic                 exValid,           // Legal instruction present
   input  logic                 exIllegal,         // Illegal instruction present
   input  sdlxPkg::aluOp_t      exOp,
   input  logic [dataWidth-1:0] exA,
   input  logic [dataWidth-1:0] exB,
   input  sdlxPkg::regIdx_t     exDest,
   output logic                 wrEn,              // To regFile and decode bypass
   output sdlxPkg::regIdx_t     wrAddr,
   output logic [dataWidth-1:0] wrData,
   output logic                 resultValid,       // One pulse per legal instruction
   output logic [dataWidth-1:0] result,
   output sdlxPkg::regIdx_t     resultReg,
   output logic                 illegal            // One pulse per illegal instruction
);

   logic [dataWidth-1:0] aluY;

   alu #(
      .dataWidth (dataWidth)
   ) aluUnit (
      .a  (exA),
      .b  (exB),
      .op (exOp),
      .y  (aluY)
   );

   // Writeback is combinational, committed at the regFile edge
   assign wrEn   = exValid;
   assign wrAddr = exDest;
   assign wrData = aluY;

   always_ff @(posedge clk) begin
      if (rst) begin
         resultValid <= 1'b0;
         illegal     <= 1'b0;
      end else begin
         resultValid <= exValid;                   // Also for writes to r0
         illegal     <= exIllegal;
      end
   end

   always_ff @(posedge clk) begin
      if (exValid) begin
         result    <= aluY;                        // Holds last result otherwise
         resultReg <= exDest;
      end
   end

   // Decode never sends one slot as both legal and illegal
   assert property (@(posedge clk) disable iff (rst) !(exValid && exIllegal))
      else $error("exValid and exIllegal high together");

   // Op registered in decode must be known once out of reset
   assert property (@(posedge clk) disable iff (rst) !$isunknown(exOp))
      else $error("ALU op unknown");

endmodule

//--- regFile.sv
`timescale 1ns/100ps

module regFile #(
   parameter int dataWidth = 32                    // Register width
) (
   input  logic                 clk,
   input  logic                 rst,
   input  sdlxPkg::regIdx_t     rdAddrA,           // Read port A index
   input  sdlxPkg::regIdx_t     rdAddrB,           // Read port B index
   output logic [dataWidth-1:0] rdDataA,           // Read port A data, combinational
   output logic [dataWidth-1:0] rdDataB,           // Read port B data, combinational
   input  logic                 wrEn,              // Write strobe
   input  sdlxPkg::regIdx_t     wrAddr,            // Write index
   input  logic [dataWidth-1:0] wrData             // Write data
);

   import sdlxPkg::*;

   logic [dataWidth-1:0] regs [REG_COUNT];

   always_ff @(posedge clk) begin
      if (rst) begin
         for (int i = 0; i < REG_COUNT; i++) begin
            regs[i] <= '0;                         // All registers start at zero
         end
      end else if (wrEn && (wrAddr != '0)) begin
         regs[wrAddr] <= wrData;                   // r0 never written
      end
   end

   // r0 reads as zero whatever the array holds
   assign rdDataA = (rdAddrA == '0) ? '0 : regs[rdAddrA];
   assign rdDataB = (rdAddrB == '0) ? '0 : regs[rdAddrB];

endmodule

//--- run.sh
#!/bin/sh
# Build with Verilator, run, then decide the outcome from the log
rm -f sim.log
verilator --binary --timing --assert -f all.f --top-module sdlxExecTb -o simv > build.log 2>&1 \
   || { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/simv > sim.log 2>&1
cat sim.log
grep -qF "*** TEST FAILED ***" sim.log && { echo "Simulation failed"; exit 1; }
grep -qF "*** TEST PASSED ***" sim.log || { echo "Simulation ended without passing"; exit 1; }
echo "Simulation passed"

//--- sdlxExec.sv
`timescale 1ns/100ps

module sdlxExec #(
   parameter int dataWidth = 32                    // Datapath width, 8, 16 or 32
) (
   input  logic                            clk,
   input  logic                            rst,
   input  logic                            instrValid,   // One instruction per strobe
   input  logic [sdlxPkg::INSTR_WIDTH-1:0] instr,
   output logic                            resultValid,
   output logic [dataWidth-1:0]            result,
   output sdlxPkg::regIdx_t                resultReg,    // Destination of result
   output logic                            illegal
);

   import sdlxPkg::*;

   regIdx_t              rdAddrA;
   regIdx_t              rdAddrB;
   logic [dataWidth-1:0] rdDataA;
   logic [dataWidth-1:0] rdDataB;
   logic                 wrEn;
   regIdx_t              wrAddr;
   logic [dataWidth-1:0] wrData;
   logic                 exValid;
   logic                 exIllegal;
   aluOp_t               exOp;
   logic [dataWidth-1:0] exA;
   logic [dataWidth-1:0] exB;
   regIdx_t              exDest;

   decodeStage #(
      .dataWidth (dataWidth)
   ) decode (
      .clk        (clk),
      .rst        (rst),
      .instrValid (instrValid),
      .instr      (instr),
      .rdAddrA    (rdAddrA),
      .rdAddrB    (rdAddrB),
      .rdDataA    (rdDataA),
      .rdDataB    (rdDataB),
      .wrEn       (wrEn),
      .wrAddr     (wrAddr),
      .wrData     (wrData),
      .exValid    (exValid),
      .exIllegal  (exIllegal),
      .exOp       (exOp),
      .exA        (exA),
      .exB        (exB),
      .exDest     (exDest)
   );

   regFile #(
      .dataWidth (dataWidth)
   ) regs (
      .clk     (clk),
      .rst     (rst),
      .rdAddrA (rdAddrA),
      .rdAddrB (rdAddrB),
      .rdDataA (rdDataA),
      .rdDataB (rdDataB),
      .wrEn    (wrEn),
      .wrAddr  (wrAddr),
      .wrData  (wrData)
   );

   executeStage #(
      .dataWidth (dataWidth)
   ) execute (
      .clk         (clk),
      .rst         (rst),
      .exValid     (exValid),
      .exIllegal   (exIllegal),
      .exOp        (exOp),
      .exA         (exA),
      .exB         (exB),
      .exDest      (exDest),
      .wrEn        (wrEn),
      .wrAddr      (wrAddr),
      .wrData      (wrData),
      .resultValid (resultValid),
      .result      (result),
      .resultReg   (resultReg),
      .illegal     (illegal)
   );

endmodule

//--- sdlxExecTb.sv
`timescale 1ns/100ps

module sdlxExecTb;

   import sdlxPkg::*;

   localparam int dataWidth      = 32;
   localparam int RESET_CYCLES   = 10;
   localparam int RANDOM_COUNT   = 200;
   localparam int TEST_BUDGET    = 60;                         // Generous budget per directed test
   localparam int TIMEOUT_CYCLES = 3 * (RESET_CYCLES + 5 * TEST_BUDGET + 2 * RANDOM_COUNT) / 2;

   logic                   clk;
   logic                   rst;
   logic                   instrValid;
   logic [INSTR_WIDTH-1:0] instr;
   logic                   resultValid;
   logic [dataWidth-1:0]   result;
   regIdx_t                resultReg;
   logic                   illegal;

   logic [dataWidth-1:0] refRegs [REG_COUNT];                  // Architectural register model
   bit                   expIllegal [$];                       // Expected output events, in order
   regIdx_t              expReg [$];
   logic [dataWidth-1:0] expValue [$];
   bit                   obsIllegal [$];                       // Events seen at the DUT outputs
   regIdx_t              obsReg [$];
   logic [dataWidth-1:0] obsValue [$];
   logic [1:0]           issuedPipe;                           // instrValid at the last two edges
   string                testName;
   int                   cycles;
   integer               seed;

   sdlxExec #(
      .dataWidth (dataWidth)
   ) uut (
      .clk         (clk),
      .rst         (rst),
      .instrValid  (instrValid),
      .instr       (instr),
      .resultValid (resultValid),
      .result      (result),
      .resultReg   (resultReg),
      .illegal     (illegal)
   );

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;                                   // 20 ns period
   end

   always @(posedge clk) begin
      cycles = cycles + 1;
      if (cycles >= TIMEOUT_CYCLES) begin
         $display("ERROR: %s did not finish within %0d cycles", testName, TIMEOUT_CYCLES);
         $display("*** TEST FAILED ***");
         $fatal(1, "Timeout");
      end
   end

   // Decode samples at one edge and the outputs follow at the next
   always @(posedge clk) begin
      if (rst) begin
         issuedPipe <= '0;
      end else begin
         issuedPipe <= {issuedPipe[0], instrValid};
      end
   end

   // Output monitor sampling mid-cycle where outputs are stable
   always @(negedge clk) begin
      if (!rst) begin
         if (resultValid && illegal) begin
            $display("ERROR: %s: resultValid and illegal high in one cycle", testName);
            $display("*** TEST FAILED ***");
            $fatal(1, "Conflicting output pulses");
         end
         checkFlag(testName, issuedPipe[1], resultValid || illegal); // Two cycles after drive
         if (resultValid || illegal) begin
            obsIllegal.push_back(illegal);
            obsReg.push_back(resultReg);
            obsValue.push_back(result);
         end
      end
   end

   task automatic checkResult(input string name, input logic [dataWidth-1:0] exp,
                              input logic [dataWidth-1:0] act);
      if (act !== exp) begin
         $display("CHECK FAILED %s: result expected %h actual %h", name, exp, act);
         $display("*** TEST FAILED ***");
         $fatal(1, "Result mismatch");
      end
   endtask

   task automatic checkReg(input string name, input regIdx_t exp, input regIdx_t act);
      if (act !== exp) begin
         $display("CHECK FAILED %s: resultReg expected %0d actual %0d", name, exp, act);
         $display("*** TEST FAILED ***");
         $fatal(1, "Destination mismatch");
      end
   endtask

   task automatic checkFlag(input string name, input logic exp, input logic act);
      if (act !== exp) begin
         $display("CHECK FAILED %s: flag expected %b actual %b", name, exp, act);
         $display("*** TEST FAILED ***");
         $fatal(1, "Flag mismatch");
      end
   endtask

   function automatic logic [31:0] rType(input regIdx_t rs1, input regIdx_t rs2,
                                         input regIdx_t rd, input func_t fn);
      return {OP_RTYPE, rs1, rs2, rd, 5'd0, fn};
   endfunction

   function automatic logic [31:0] addi(input regIdx_t rs1, input regIdx_t rt,
                                        input logic [15:0] imm);
      return {OP_ADDI, rs1, rt, imm};
   endfunction

   function automatic func_t pickFunc(input int sel);
      case (sel)
         0:       return FN_ADD;
         1:       return FN_SUB;
         2:       return FN_AND;
         3:       return FN_OR;
         4:       return FN_SLL;
         5:       return FN_SRL;
         default: return FN_MUL;
      endcase
   endfunction

   // Reference model executing one word in program order
   task automatic predict(input logic [31:0] word);
      func_t                  fn;
      regIdx_t                dest;
      logic [dataWidth-1:0]   a;
      logic [dataWidth-1:0]   b;
      logic [dataWidth-1:0]   y;
      logic [31:0]            immExt;
      logic [2*dataWidth-1:0] prod;
      bit                     legal;
      fn     = word[5:0];
      a      = refRegs[word[25:21]];
      b      = refRegs[word[20:16]];
      dest   = word[15:11];
      legal  = 1'b1;
      y      = '0;
      immExt = {{16{word[15]}}, word[15:0]};                   // Sign extend, then truncate
      prod   = {{dataWidth{1'b0}}, a} * {{dataWidth{1'b0}}, b};
      if (word[31:26] == OP_ADDI) begin
         dest = word[20:16];
         y    = a + immExt[dataWidth-1:0];
      end else if (word[31:26] == OP_RTYPE) begin
         case (fn)
            FN_ADD:  y = a + b;
            FN_SUB:  y = a - b;
            FN_MUL:  y = prod[dataWidth-1:0];                  // Low half only
            FN_AND:  y = a & b;
            FN_OR:   y = a | b;
            FN_SLL:  y = a << (b % dataWidth);
            FN_SRL:  y = a >> (b % dataWidth);
            default: legal = 1'b0;
         endcase
      end else begin
         legal = 1'b0;
      end
      expIllegal.push_back(!legal);
      expReg.push_back(legal ? dest : '0);
      expValue.push_back(y);
      if (legal && (dest != '0)) begin
         refRegs[dest] = y;                                    // r0 stays zero
      end
   endtask

   task automatic issue(input logic [31:0] word);
      @(negedge clk);
      instrValid = 1'b1;
      instr      = word;
      predict(word);
   endtask

   task automatic idle();
      @(negedge clk);
      instrValid = 1'b0;
      instr      = '0;
   endtask

   // Wait for all expected events, then compare them in order
   task automatic drain();
      idle();
      while (obsIllegal.size() < expIllegal.size()) begin
         @(posedge clk);
      end
      repeat (3) @(posedge clk);                               // Window for stray pulses
      if (obsIllegal.size() != expIllegal.size()) begin
         $display("ERROR: %s: expected %0d output pulses but the DUT gave %0d",
                  testName, expIllegal.size(), obsIllegal.size());
         $display("*** TEST FAILED ***");
         $fatal(1, "Pulse count mismatch");
      end
      foreach (expIllegal[i]) begin
         checkFlag(testName, expIllegal[i], obsIllegal[i]);
         if (!expIllegal[i]) begin
            checkReg(testName, expReg[i], obsReg[i]);
            checkResult(testName, expValue[i], obsValue[i]);
         end
      end
      expIllegal.delete();
      expReg.delete();
      expValue.delete();
      obsIllegal.delete();
      obsReg.delete();
      obsValue.delete();
   endtask

   task automatic resetTest();
      testName = "reset";
      repeat (4) begin
         @(negedge clk);
         checkFlag(testName, 1'b0, resultValid);               // Quiet after reset
         checkFlag(testName, 1'b0, illegal);
      end
      issue(rType(5'd0, 5'd0, 5'd1, FN_ADD));
      drain();
   endtask

   task automatic addiTest();
      testName = "addi";
      issue(addi(5'd0, 5'd2, 16'd100));
      drain();
      issue(addi(5'd2, 5'd3, 16'hFFF6));                       // Minus ten
      issue(addi(5'd0, 5'd4, 16'h8000));                       // Most negative imm
      issue(addi(5'd4, 5'd5, 16'h7FFF));
      drain();
   endtask

   task automatic rtypeTest();
      testName = "rtype";
      issue(addi(5'd0, 5'd6, 16'h7FFF));
      issue(addi(5'd0, 5'd7, 16'hFFFD));
      issue(addi(5'd0, 5'd8, 16'd5));
      drain();
      issue(rType(5'd7, 5'd7, 5'd9, FN_ADD));                  // Wraps
      issue(rType(5'd8, 5'd6, 5'd10, FN_SUB));
      issue(rType(5'd6, 5'd7, 5'd11, FN_MUL));
      issue(rType(5'd7, 5'd7, 5'd12, FN_MUL));
      issue(rType(5'd6, 5'd8, 5'd13, FN_SLL));
      issue(rType(5'd6, 5'd7, 5'd14, FN_SLL));                 // Amount from low bits only
      issue(rType(5'd7, 5'd8, 5'd15, FN_SRL));
      issue(rType(5'd6, 5'd7, 5'd16, FN_AND));
      issue(rType(5'd8, 5'd7, 5'd17, FN_OR));
      drain();
   endtask

   task automatic chainTest();
      testName = "chain";
      issue(addi(5'd0, 5'd22, 16'd3));
      issue(rType(5'd22, 5'd22, 5'd23, FN_ADD));               // Both operands bypassed
      issue(rType(5'd23, 5'd22, 5'd24, FN_MUL));
      issue(rType(5'd24, 5'd23, 5'd25, FN_SUB));
      issue(rType(5'd22, 5'd25, 5'd26, FN_SLL));               // B from previous dest
      issue(addi(5'd26, 5'd26, 16'hFFFF));
      drain();
   endtask

   task automatic zeroIllegalTest();
      testName = "zeroIllegal";
      issue(rType(5'd6, 5'd8, 5'd0, FN_ADD));                  // Shown but not stored
      issue(rType(5'd0, 5'd0, 5'd20, FN_ADD));
      issue({6'd35, 5'd0, 5'd6, 16'h1234});                    // Unsupported load word
      issue(rType(5'd6, 5'd8, 5'd6, 6'd33));                   // Unsupported function
      issue(rType(5'd6, 5'd0, 5'd21, FN_OR));                  // r6 unchanged
      drain();
   endtask

   task automatic randomTest();
      logic [31:0] word;
      int          kind;
      testName = "random";
      for (int i = 0; i < RANDOM_COUNT; i++) begin
         kind = $unsigned($random(seed)) % 8;
         word = $random(seed);
         if (kind < 4) begin
            word = rType(word[25:21], word[20:16], word[15:11],
                         pickFunc($unsigned($random(seed)) % 7));
         end else if (kind < 6) begin
            word[31:26] = OP_ADDI;
         end
         if (($random(seed) & 3) == 0) begin
            idle();                                            // Gap in the stream
         end
         issue(word);
      end
      drain();
   endtask

   initial begin
      rst        = 1'b1;
      instrValid = 1'b0;
      instr      = '0;
      seed       = 42;
      cycles     = 0;
      testName   = "reset";
      foreach (refRegs[i]) begin
         refRegs[i] = '0;
      end
      repeat (RESET_CYCLES) @(negedge clk);
      rst = 1'b0;
      resetTest();
      addiTest();
      rtypeTest();
      chainTest();
      zeroIllegalTest();
      randomTest();
      $display("*** TEST PASSED ***");
      $finish;
   end

endmodule

//--- sdlxPkg.sv
package sdlxPkg;

   localparam int INSTR_WIDTH = 32;                // Instruction word width
   localparam int REG_COUNT   = 32;                // Architectural registers, r0 included

   typedef logic [$clog2(REG_COUNT)-1:0] regIdx_t; // Register index
   typedef logic [5:0] opcode_t;                   // Primary opcode field
   typedef logic [5:0] func_t;                     // R-type function field

   // ALU operation select, driven by aluControl
   typedef enum logic [2:0] {
      aluAnd = 3'd0,                               // Bitwise and
      aluOr  = 3'd1,                               // Bitwise or
      aluShl = 3'd2,                               // Logical shift left
      aluShr = 3'd3,                               // Logical shift right
      aluAdd = 3'd4,                               // Wrapping add
      aluSub = 3'd5,                               // Wrapping subtract
      aluMul = 3'd6                                // Low half of product
   } aluOp_t;

   // Opcodes
   localparam opcode_t OP_RTYPE = 6'd0;            // Register-register group
   localparam opcode_t OP_ADDI  = 6'd8;            // Add immediate

   // R-type function codes
   localparam func_t FN_SLL = 6'd4;
   localparam func_t FN_SRL = 6'd6;
   localparam func_t FN_MUL = 6'd14;
   localparam func_t FN_ADD = 6'd32;
   localparam func_t FN_SUB = 6'd34;
   localparam func_t FN_AND = 6'd36;
   localparam func_t FN_OR  = 6'd37;

   // Instruction field positions
   localparam int OPC_HI = 31;                     // Opcode
   localparam int OPC_LO = 26;
   localparam int RS1_HI = 25;                     // First source
   localparam int RS1_LO = 21;
   localparam int RS2_HI = 20;                     // Second source, I-type dest
   localparam int RS2_LO = 16;
   localparam int RD_HI  = 15;                     // R-type dest
   localparam int RD_LO  = 11;
   localparam int IMM_HI = 15;                     // 16-bit immediate
   localparam int IMM_LO = 0;
   localparam int FN_HI  = 5;                      // Function code
   localparam int FN_LO  = 0;

endpackage
